/* src.f */
src/rot_pkg.sv
src/loop_counter.sv
src/weight_bank.sv
src/weight_writer.sv
src/weight_reader.sv
src/weight_rotator_top.sv
bench/tb_weight_rotator.sv

/* bench/tb_weight_rotator.sv */
////////////////////////////////////////
// Weight rotator testbench
// Reference model, compare tasks, tests
////////////////////////////////////////
`default_nettype none

module tb_weight_rotator;

  typedef struct packed {
    logic                       last;
    rot_pkg::tuser_t            user;
    logic [rot_pkg::BEAT_W-1:0] data;
  } beat_t;

  localparam int TIMEOUT = 500;

  logic                       aclk;
  logic                       aresetn;
  logic                       i_s_tvalid;
  logic                       o_s_tready;
  logic [rot_pkg::BEAT_W-1:0] i_s_tdata;
  logic                       i_s_tlast;
  logic                       o_m_tvalid;
  logic                       i_m_tready;
  logic [rot_pkg::BEAT_W-1:0] o_m_tdata;
  logic                       o_m_tlast;
  rot_pkg::tuser_t            o_m_tuser;

  logic [31:0]                rng_state;
  int                         errors;
  int                         tests_run;
  int                         tests_failed;
  int                         tlast_count;
  int                         in_done_tlasts;
  logic [rot_pkg::BEAT_W-1:0] cfg_buf [rot_pkg::CFG_BEATS];
  logic [rot_pkg::BEAT_W-1:0] w_buf [rot_pkg::BANK_DEPTH];
  // Input beats as {tlast, tdata}
  logic [rot_pkg::BEAT_W:0]   in_q[$];
  logic [rot_pkg::BEAT_W:0]   saved_in[$];
  beat_t                      exp_q[$];
  beat_t                      saved_exp[$];

  weight_rotator_top i_weight_rotator_top (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_tvalid(i_s_tvalid), .o_s_tready(o_s_tready),
    .i_s_tdata(i_s_tdata), .i_s_tlast(i_s_tlast),
    .o_m_tvalid(o_m_tvalid), .i_m_tready(i_m_tready),
    .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = !aclk;
  end

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic step();
    @(posedge aclk);
    #1;
  endtask

  task automatic check_beat(input string name,
                            input logic [rot_pkg::BEAT_W-1:0] exp_data, input logic exp_last,
                            input logic [rot_pkg::BEAT_W-1:0] act_data, input logic act_last);
    if (act_data !== exp_data || act_last !== exp_last) begin
      errors++;
      $display("MISMATCH %s: expected data %h last %b, actual data %h last %b",
               name, exp_data, exp_last, act_data, act_last);
    end
  endtask

  task automatic check_user(input string name,
                            input rot_pkg::tuser_t exp_user, input rot_pkg::tuser_t act_user);
    if (act_user !== exp_user) begin
      errors++;
      $display("MISMATCH %s: expected tuser %b, actual tuser %b", name, exp_user, act_user);
    end
  endtask

  function automatic rot_pkg::header_t make_header(input int kw, input int cin, input int cols,
                                                   input int blocks, input int xn);
    rot_pkg::header_t h;
    h.kw2      = rot_pkg::KW2_W'((kw - 1) / 2);
    h.cin_1    = rot_pkg::CIN_W'(cin - 1);
    h.cols_1   = rot_pkg::COLS_W'(cols - 1);
    h.blocks_1 = rot_pkg::BLK_W'(blocks - 1);
    h.xn_1     = rot_pkg::XN_W'(xn - 1);
    return h;
  endfunction

  // Flags from kernel, channel and column positions
  function automatic rot_pkg::tuser_t flags_for(input rot_pkg::header_t h, input logic cfg,
                                                input int k, input int ci, input int c);
    rot_pkg::tuser_t u;
    u.is_config      = cfg;
    u.kw2            = h.kw2;
    u.is_w_first_clk = (c == 0) && (ci == 0) && (k == 0);
    u.is_cin_last    = (k == 2 * int'(h.kw2)) && (ci == int'(h.cin_1));
    u.is_w_first_kw2 = (int'(h.cols_1) - c) < int'(h.kw2);
    u.is_w_last      = (c == int'(h.cols_1));
    return u;
  endfunction

  task automatic build_expected(input rot_pkg::header_t h);
    int    kw;
    beat_t b;
    kw = 2 * int'(h.kw2) + 1;
    for (int i = 0; i < rot_pkg::CFG_BEATS; i++) begin
      b.data = cfg_buf[i];
      b.last = 1'b0;
      b.user = flags_for(h, 1'b1, 0, 0, 0);
      exp_q.push_back(b);
    end
    // Weights replayed cols x blocks x xn times
    for (int x = 0; x <= int'(h.xn_1); x++) begin
      for (int bl = 0; bl <= int'(h.blocks_1); bl++) begin
        for (int c = 0; c <= int'(h.cols_1); c++) begin
          for (int ci = 0; ci <= int'(h.cin_1); ci++) begin
            for (int k = 0; k < kw; k++) begin
              b.data = w_buf[ci * kw + k];
              b.user = flags_for(h, 1'b0, k, ci, c);
              b.last = (x == int'(h.xn_1)) && (bl == int'(h.blocks_1)) &&
                       (c == int'(h.cols_1)) && (ci == int'(h.cin_1)) && (k == kw - 1);
              exp_q.push_back(b);
            end
          end
        end
      end
    end
  endtask

  task automatic add_frame(input rot_pkg::header_t h);
    int                         n_w;
    logic [rot_pkg::BEAT_W-1:0] hdr_beat;
    n_w = (2 * int'(h.kw2) + 1) * (int'(h.cin_1) + 1);
    hdr_beat = '0;
    hdr_beat[$bits(rot_pkg::header_t)-1:0] = h;
    in_q.push_back({1'b0, hdr_beat});
    for (int i = 0; i < rot_pkg::CFG_BEATS; i++) begin
      cfg_buf[i] = xorshift();
      in_q.push_back({1'b0, cfg_buf[i]});
    end
    for (int i = 0; i < n_w; i++) begin
      w_buf[i] = xorshift();
      in_q.push_back({(i == n_w - 1), w_buf[i]});
    end
    build_expected(h);
  endtask

  task automatic drive_input();
    int waits;
    waits = 0;
    while (in_q.size() > 0 && waits < TIMEOUT) begin
      i_s_tvalid = 1'b1;
      {i_s_tlast, i_s_tdata} = in_q[0];
      if (o_s_tready) begin
        void'(in_q.pop_front());
        waits = 0;
        if (in_q.size() == 0) begin
          in_done_tlasts = tlast_count;
        end
      end else begin
        waits++;
      end
      step();
    end
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
    if (waits >= TIMEOUT) begin
      errors++;
      $display("ERROR: input stream stalled, o_s_tready stayed low too long");
    end
  endtask

  task automatic collect_output(input string name, input bit rand_ready);
    int          waits;
    bit          held;
    logic [31:0] rnd;
    beat_t       hold_beat;
    beat_t       act;
    beat_t       exp;
    waits = 0;
    held  = 1'b0;
    while (exp_q.size() > 0 && waits < TIMEOUT) begin
      if (rand_ready) begin
        rnd = xorshift();
        i_m_tready = rnd[3];
      end else begin
        i_m_tready = 1'b1;
      end
      act.data = o_m_tdata;
      act.last = o_m_tlast;
      act.user = o_m_tuser;
      // A stalled beat must come back unchanged
      if (held && !o_m_tvalid) begin
        errors++;
        $display("ERROR: %s: o_m_tvalid dropped before the beat transferred", name);
      end else if (held) begin
        check_beat({name, " hold"}, hold_beat.data, hold_beat.last, act.data, act.last);
        check_user({name, " hold"}, hold_beat.user, act.user);
      end
      held = 1'b0;
      if (o_m_tvalid && i_m_tready) begin
        exp = exp_q.pop_front();
        check_beat(name, exp.data, exp.last, act.data, act.last);
        check_user(name, exp.user, act.user);
        if (act.last) begin
          tlast_count++;
        end
        waits = 0;
      end else begin
        held      = o_m_tvalid;
        hold_beat = act;
        waits++;
      end
      step();
    end
    i_m_tready = 1'b0;
    if (waits >= TIMEOUT) begin
      errors++;
      $display("ERROR: %s: output timed out with %0d beats missing", name, exp_q.size());
    end else if (o_m_tvalid) begin
      errors++;
      $display("ERROR: %s: extra output beat after the expected sequence", name);
    end
  endtask

  task automatic run_frames(input string name, input bit rand_ready);
    fork
      drive_input();
      collect_output(name, rand_ready);
    join
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  task automatic test_reset();
    int e;
    int waits;
    e = errors;
    if (o_m_tvalid !== 1'b0 || o_m_tlast !== 1'b0) begin
      errors++;
      $display("ERROR: reset: output stream is active after reset");
    end
    waits = 0;
    while (o_s_tready !== 1'b1 && waits < TIMEOUT) begin
      step();
      waits++;
    end
    if (waits >= TIMEOUT) begin
      errors++;
      $display("ERROR: reset: o_s_tready never rose");
    end
    finish_test("reset", e);
  endtask

  task automatic test_single_frame();
    int e;
    e = errors;
    in_q.delete();
    exp_q.delete();
    add_frame(make_header(3, 2, 2, 1, 1));
    saved_in  = in_q;
    saved_exp = exp_q;
    run_frames("single_frame", 1'b0);
    finish_test("single_frame", e);
  endtask

  task automatic test_flags();
    int e;
    e = errors;
    in_q.delete();
    exp_q.delete();
    add_frame(make_header(5, 3, 4, 2, 2));
    run_frames("user_flags", 1'b0);
    finish_test("user_flags", e);
  endtask

  task automatic test_backpressure();
    int e;
    e = errors;
    in_q  = saved_in;
    exp_q = saved_exp;
    run_frames("backpressure", 1'b1);
    finish_test("backpressure", e);
  endtask

  task automatic test_back_to_back();
    int e;
    int start_tlasts;
    e = errors;
    in_q.delete();
    exp_q.delete();
    add_frame(make_header(5, 3, 4, 2, 2));
    add_frame(make_header(1, 4, 3, 1, 2));
    start_tlasts   = tlast_count;
    in_done_tlasts = -1;
    run_frames("back_to_back", 1'b0);
    // Second frame fully written before the first frame's tlast left
    if (in_done_tlasts != start_tlasts) begin
      errors++;
      $display("ERROR: back_to_back: second frame was not accepted during the first replay");
    end
    finish_test("back_to_back", e);
  endtask

  initial begin
    rng_state      = 32'd44;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    tlast_count    = 0;
    in_done_tlasts = -1;
    aresetn        = 1'b0;
    i_s_tvalid     = 1'b0;
    i_s_tdata      = '0;
    i_s_tlast      = 1'b0;
    i_m_tready     = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    aresetn = 1'b1;
    test_reset();
    test_single_frame();
    test_flags();
    test_backpressure();
    test_back_to_back();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/weight_rotator_top.sv */
////////////////////////////////////////
// Weight rotator top level
// Writer, two ping-pong banks, reader
////////////////////////////////////////
`default_nettype none

module weight_rotator_top (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       i_s_tvalid,
  output logic                       o_s_tready,
  input  logic [rot_pkg::BEAT_W-1:0] i_s_tdata,
  input  logic                       i_s_tlast,
  output logic                       o_m_tvalid,
  input  logic                       i_m_tready,
  output logic [rot_pkg::BEAT_W-1:0] o_m_tdata,
  output logic                       o_m_tlast,
  output rot_pkg::tuser_t            o_m_tuser
);

  logic [1:0]                 wr_en;
  logic [1:0]                 wr_clear;
  logic [1:0]                 full;
  logic [1:0]                 free;
  logic [1:0]                 rd_en;
  logic [1:0]                 rd_restart;
  logic [rot_pkg::BEAT_W-1:0] rd_data0;
  logic [rot_pkg::BEAT_W-1:0] rd_data1;
  rot_pkg::header_t           header0;
  rot_pkg::header_t           header1;

  weight_writer i_weight_writer (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_tvalid(i_s_tvalid), .i_s_tdata(i_s_tdata), .i_s_tlast(i_s_tlast),
    .i_free(free), .o_s_tready(o_s_tready),
    .o_wr_en(wr_en), .o_wr_clear(wr_clear), .o_full(full),
    .o_header0(header0), .o_header1(header1)
  );

  // Ping-pong banks share the input data
  weight_bank i_weight_bank0 (
    .aclk(aclk), .aresetn(aresetn),
    .i_wr_en(wr_en[0]), .i_wr_clear(wr_clear[0]), .i_wr_data(i_s_tdata),
    .i_rd_en(rd_en[0]), .i_rd_restart(rd_restart[0]), .o_rd_data(rd_data0)
  );

  weight_bank i_weight_bank1 (
    .aclk(aclk), .aresetn(aresetn),
    .i_wr_en(wr_en[1]), .i_wr_clear(wr_clear[1]), .i_wr_data(i_s_tdata),
    .i_rd_en(rd_en[1]), .i_rd_restart(rd_restart[1]), .o_rd_data(rd_data1)
  );

  weight_reader i_weight_reader (
    .aclk(aclk), .aresetn(aresetn),
    .i_full(full), .i_header0(header0), .i_header1(header1),
    .i_rd_data0(rd_data0), .i_rd_data1(rd_data1), .i_m_tready(i_m_tready),
    .o_free(free), .o_rd_en(rd_en), .o_rd_restart(rd_restart),
    .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata),
    .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

endmodule

`default_nettype wire

/* src/weight_reader.sv */
////////////////////////////////////////
// Read FSM, nested loop counters, skid
// register, user flags and free flags
////////////////////////////////////////
`default_nettype none

module weight_reader (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic [1:0]                 i_full,
  input  rot_pkg::header_t           i_header0,
  input  rot_pkg::header_t           i_header1,
  input  logic [rot_pkg::BEAT_W-1:0] i_rd_data0,
  input  logic [rot_pkg::BEAT_W-1:0] i_rd_data1,
  input  logic                       i_m_tready,
  output logic [1:0]                 o_free,
  output logic [1:0]                 o_rd_en,
  output logic [1:0]                 o_rd_restart,
  output logic                       o_m_tvalid,
  output logic [rot_pkg::BEAT_W-1:0] o_m_tdata,
  output logic                       o_m_tlast,
  output rot_pkg::tuser_t            o_m_tuser
);

  typedef enum logic [1:0] {
    st_idle,
    st_config,
    st_read,
    st_switch
  } state_t;

  typedef struct packed {
    logic                       last;
    rot_pkg::tuser_t            user;
    logic [rot_pkg::BEAT_W-1:0] data;
  } beat_t;

  state_t                     state;
  logic                       idx;
  rot_pkg::header_t           hdr;
  rot_pkg::tuser_t            user;
  logic                       clear;
  logic                       issue;
  logic                       pop;
  logic                       push;
  logic                       deq;
  logic                       lc_cfg, lc_kw, lc_cin, lc_cols, lc_blk, lc_xn;
  logic                       f_kw, f_cin, f_cols, l_kw, l_cin, l_cols;
  logic [rot_pkg::COLS_W-1:0] c_cols;
  logic [rot_pkg::COLS_W-1:0] cols_left;
  // Read in flight and its flags
  logic                       pend;
  logic                       pend_last;
  rot_pkg::tuser_t            pend_user;
  beat_t                      land_beat;
  beat_t                      out_beat;
  beat_t                      skid [2];
  logic [1:0]                 cnt;
  logic                       sk_wr;
  logic                       sk_rd;

  assign hdr   = idx ? i_header1 : i_header0;
  assign clear = !aresetn || (state == st_idle);

  // Issue only when the skid can absorb the result
  assign pop   = o_m_tvalid && i_m_tready;
  assign issue = (state == st_config || state == st_read) &&
                 (3'(cnt) + 3'(pend) <= 3'd1 + 3'(pop));

  assign o_rd_en      = issue ? (2'b01 << idx) : 2'b00;
  assign o_rd_restart = lc_cin ? (2'b01 << idx) : 2'b00;

  loop_counter #(.W(rot_pkg::CFG_W)) i_cnt_cfg (
    .aclk(aclk), .i_clear(clear), .i_en(issue && state == st_config),
    .i_max(rot_pkg::CFG_LAST), .o_count(), .o_first(), .o_last(), .o_last_en(lc_cfg)
  );
  loop_counter #(.W(rot_pkg::KW_W)) i_cnt_kw (
    .aclk(aclk), .i_clear(clear), .i_en(issue && state == st_read),
    .i_max({hdr.kw2, 1'b0}), .o_count(), .o_first(f_kw), .o_last(l_kw), .o_last_en(lc_kw)
  );
  loop_counter #(.W(rot_pkg::CIN_W)) i_cnt_cin (
    .aclk(aclk), .i_clear(clear), .i_en(lc_kw),
    .i_max(hdr.cin_1), .o_count(), .o_first(f_cin), .o_last(l_cin), .o_last_en(lc_cin)
  );
  loop_counter #(.W(rot_pkg::COLS_W)) i_cnt_cols (
    .aclk(aclk), .i_clear(clear), .i_en(lc_cin),
    .i_max(hdr.cols_1), .o_count(c_cols), .o_first(f_cols), .o_last(l_cols),
    .o_last_en(lc_cols)
  );
  loop_counter #(.W(rot_pkg::BLK_W)) i_cnt_blk (
    .aclk(aclk), .i_clear(clear), .i_en(lc_cols),
    .i_max(hdr.blocks_1), .o_count(), .o_first(), .o_last(), .o_last_en(lc_blk)
  );
  loop_counter #(.W(rot_pkg::XN_W)) i_cnt_xn (
    .aclk(aclk), .i_clear(clear), .i_en(lc_blk),
    .i_max(hdr.xn_1), .o_count(), .o_first(), .o_last(), .o_last_en(lc_xn)
  );

  // Flags belong to the address being issued
  assign cols_left           = hdr.cols_1 - c_cols;
  assign user.is_config      = (state == st_config);
  assign user.kw2            = hdr.kw2;
  assign user.is_w_first_clk = f_cols && f_cin && f_kw;
  assign user.is_cin_last    = l_kw && l_cin;
  assign user.is_w_first_kw2 = cols_left < hdr.kw2;
  assign user.is_w_last      = l_cols;

  // Empty skid passes the bank output straight through
  assign land_beat  = '{last: pend_last, user: pend_user, data: idx ? i_rd_data1 : i_rd_data0};
  assign out_beat   = (cnt != 2'd0) ? skid[sk_rd] : land_beat;
  assign o_m_tvalid = (cnt != 2'd0) || pend;
  assign o_m_tdata  = out_beat.data;
  assign o_m_tuser  = out_beat.user;
  assign o_m_tlast  = o_m_tvalid && out_beat.last;
  assign push       = pend && ((cnt != 2'd0) || !pop);
  assign deq        = pop && (cnt != 2'd0);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      pend  <= 1'b0;
      cnt   <= 2'd0;
      sk_wr <= 1'b0;
      sk_rd <= 1'b0;
    end else begin
      pend <= issue;
      cnt  <= cnt + 2'(push) - 2'(deq);
      if (push) begin
        sk_wr <= !sk_wr;
      end
      if (deq) begin
        sk_rd <= !sk_rd;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (issue) begin
      pend_last <= lc_xn;
      pend_user <= user;
    end
    if (push) begin
      skid[sk_wr] <= land_beat;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= st_idle;
      idx    <= 1'b0;
      o_free <= 2'b11;
    end else begin
      case (state)
        st_idle: begin
          if (i_full[idx]) begin
            state       <= st_config;
            o_free[idx] <= 1'b0;
          end
        end
        st_config: begin
          if (lc_cfg) begin
            state <= st_read;
          end
        end
        st_read: begin
          if (lc_xn) begin
            state <= st_switch;
          end
        end
        st_switch: begin
          // Bank returns to the writer once tlast has left
          if (pop && o_m_tlast) begin
            state       <= st_idle;
            idx         <= !idx;
            o_free[idx] <= 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Stalled beat stays valid and unchanged
  assert property (@(posedge aclk) disable iff (!aresetn)
    o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata));

endmodule

`default_nettype wire

/* src/weight_writer.sv */
////////////////////////////////////////
// Write FSM, header capture, full flags
// and bank write strobes
////////////////////////////////////////
`default_nettype none

module weight_writer (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       i_s_tvalid,
  input  logic [rot_pkg::BEAT_W-1:0] i_s_tdata,
  input  logic                       i_s_tlast,
  input  logic [1:0]                 i_free,
  output logic                       o_s_tready,
  output logic [1:0]                 o_wr_en,
  output logic [1:0]                 o_wr_clear,
  output logic [1:0]                 o_full,
  output rot_pkg::header_t           o_header0,
  output rot_pkg::header_t           o_header1
);

  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_write,
    st_switch
  } state_t;

  state_t           state;
  logic             idx;
  logic             s_xfer;
  rot_pkg::header_t s_header;

  assign s_header   = rot_pkg::header_t'(i_s_tdata[$bits(rot_pkg::header_t)-1:0]);
  assign o_s_tready = (state == st_header) || (state == st_write);
  assign s_xfer     = i_s_tvalid && o_s_tready;

  // Strobes only reach the bank selected by idx
  assign o_wr_en    = (s_xfer && state == st_write) ? (2'b01 << idx) : 2'b00;
  assign o_wr_clear = (state == st_header) ? (2'b01 << idx) : 2'b00;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= st_idle;
      idx    <= 1'b0;
      o_full <= 2'b00;
    end else begin
      case (state)
        st_idle: begin
          if (i_free[idx]) begin
            state       <= st_header;
            o_full[idx] <= 1'b0;
          end
        end
        st_header: begin
          if (s_xfer) begin
            state <= st_write;
          end
        end
        st_write: begin
          // Frame complete, hand the bank to the reader
          if (s_xfer && i_s_tlast) begin
            state       <= st_switch;
            o_full[idx] <= 1'b1;
          end
        end
        st_switch: begin
          state <= st_idle;
          idx   <= !idx;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Loop sizes of each bank
  always_ff @(posedge aclk) begin
    if (s_xfer && state == st_header) begin
      if (idx) begin
        o_header1 <= s_header;
      end else begin
        o_header0 <= s_header;
      end
    end
  end

  // Never overwrite a bank the reader still owns
  assert property (@(posedge aclk) disable iff (!aresetn)
    (o_wr_en & ~i_free) == 2'b00);

endmodule

`default_nettype wire

/* src/weight_bank.sv */
////////////////////////////////////////
// Weight bank with write pointer and
// restartable read pointer
////////////////////////////////////////
`default_nettype none

module weight_bank (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       i_wr_en,
  input  logic                       i_wr_clear,
  input  logic [rot_pkg::BEAT_W-1:0] i_wr_data,
  input  logic                       i_rd_en,
  input  logic                       i_rd_restart,
  output logic [rot_pkg::BEAT_W-1:0] o_rd_data
);

  logic [rot_pkg::BEAT_W-1:0] mem [rot_pkg::BANK_DEPTH];
  // Extra bit so an overrun shows up
  logic [rot_pkg::ADDR_W:0]   wr_ptr;
  logic [rot_pkg::ADDR_W-1:0] rd_ptr;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_wr_clear) begin
      wr_ptr <= '0;
    end else if (i_wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Config beats sit below CFG_ADDR and are read once after clear
  always_ff @(posedge aclk) begin
    if (!aresetn || i_wr_clear) begin
      rd_ptr <= '0;
    end else if (i_rd_restart) begin
      rd_ptr <= rot_pkg::CFG_ADDR;
    end else if (i_rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wr_en) begin
      mem[wr_ptr[rot_pkg::ADDR_W-1:0]] <= i_wr_data;
    end
    if (i_rd_en) begin
      o_rd_data <= mem[rd_ptr];
    end
  end

  // Whole frame must fit in one bank
  assert property (@(posedge aclk) disable iff (!aresetn)
    i_wr_en |-> wr_ptr < rot_pkg::BANK_DEPTH);

endmodule

`default_nettype wire

/* src/loop_counter.sv */
////////////////////////////////////////
// Wrapping loop counter, first/last
// flags, chains through o_last_en
////////////////////////////////////////
`default_nettype none

module loop_counter #(
  parameter int W = 4
) (
  input  logic         aclk,
  input  logic         i_clear,
  input  logic         i_en,
  input  logic [W-1:0] i_max,
  output logic [W-1:0] o_count,
  output logic         o_first,
  output logic         o_last,
  output logic         o_last_en
);

  assign o_first   = (o_count == '0);
  assign o_last    = (o_count == i_max);
  // Enables the next loop level
  assign o_last_en = i_en && o_last;

  always_ff @(posedge aclk) begin
    if (i_clear) begin
      o_count <= '0;
    end else if (i_en) begin
      o_count <= o_last ? '0 : o_count + W'(1);
    end
  end

endmodule

`default_nettype wire

/* src/rot_pkg.sv */
////////////////////////////////////////
// Weight rotator sizes and widths
// Header and output user flag structs
////////////////////////////////////////
`default_nettype none

package rot_pkg;

  // Beat layout
  localparam int WORD_W = 8;
  localparam int COLS   = 4;
  localparam int BEAT_W = WORD_W * COLS;

  // Bank storage
  localparam int BANK_DEPTH = 64;
  localparam int ADDR_W     = 6;
  localparam int CFG_BEATS  = 2;
  localparam int CFG_W      = $clog2(CFG_BEATS);

  // Header field widths
  localparam int KW2_W  = 2;
  localparam int CIN_W  = 3;
  localparam int COLS_W = 4;
  localparam int BLK_W  = 2;
  localparam int XN_W   = 2;
  // Kernel counter runs up to 2*kw2
  localparam int KW_W   = KW2_W + 1;

  // First weight address, where every replay restarts
  localparam logic [ADDR_W-1:0] CFG_ADDR = ADDR_W'(CFG_BEATS);
  localparam logic [CFG_W-1:0]  CFG_LAST = CFG_W'(CFG_BEATS - 1);

  typedef struct packed {
    logic [XN_W-1:0]   xn_1;
    logic [BLK_W-1:0]  blocks_1;
    logic [COLS_W-1:0] cols_1;
    logic [CIN_W-1:0]  cin_1;
    logic [KW2_W-1:0]  kw2;
  } header_t;

  typedef struct packed {
    logic             is_config;
    logic [KW2_W-1:0] kw2;
    logic             is_w_first_clk;
    logic             is_cin_last;
    logic             is_w_first_kw2;
    logic             is_w_last;
  } tuser_t;

endpackage

`default_nettype wire
